// ==== list.f ====
+incdir+tb
source/dt_pkg.sv
source/dt_feature_store.sv
source/dt_issue_stage.sv
source/dt_node_read_stage.sv
source/dt_compare_stage.sv
source/dt_pu.sv
tb/tb_dt_pu.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the dt_pu testbench with Verilator

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_dt_pu -f list.f -Mdir "$obj_dir" -o vsim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$obj_dir/vsim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation returned status $status"
	exit 1
fi

if grep -q "Verification failed" "$log"; then
	exit 1
fi
if ! grep -q "Verification passed" "$log"; then
	echo "No result line found in $log"
	exit 1
fi
exit 0

// ==== tb/dt_pu_tests.svh ====
`ifndef DT_PU_TESTS_SVH
`define DT_PU_TESTS_SVH

////////////////////////////////////////
// Word level drivers
////////////////////////////////////////
// Entered on a falling edge and left on the one after the word is taken
task automatic send_word(input dt_pkg::word_kind_e kind, input logic [31:0] data,
	input logic last);
	in_kind  = kind;
	in_data  = data;
	in_last  = last;
	in_valid = 1'b1;
	if (kind == dt_pkg::kind_tuple) begin
		while (!in_ready) begin                     // Hold the word until there is room
			stall_seen = 1'b1;
			@(negedge clk);
		end
	end
	@(negedge clk);
	in_valid = 1'b0;
	in_last  = 1'b0;
endtask

// Copies the reference tree into the DUT
task automatic program_tree(input int depth, input logic [31:0] missing);
	ref_depth   = depth;
	ref_missing = missing;
	send_word(dt_pkg::kind_depth, 32'(depth), 1'b0);   // Restarts both counters
	send_word(dt_pkg::kind_missing, missing, 1'b0);
	for (int i = 0; i < (1 << (depth + 1)) - 1; i++) begin
		send_word(dt_pkg::kind_weight, ref_weight[i], 1'b0);
	end
	for (int i = 0; i < (1 << depth) - 1; i++) begin
		send_word(dt_pkg::kind_findex, {16'h0000, ref_findex[i]}, 1'b0);
	end
endtask

task automatic send_tuple(input int n);
	exp_q.push_back(expected_leaf());
	for (int i = 0; i < n; i++) begin
		send_word(dt_pkg::kind_tuple, tuple_buf[i], i == n - 1);
	end
endtask

task automatic wait_drain();
	int waited;
	waited = 0;
	while (exp_q.size() > 0 && waited < DRAIN_CYCLES) begin
		@(negedge clk);
		waited++;
	end
	assert (exp_q.size() == 0) else begin
		missing_cnt += exp_q.size();
		$display("%0d leaf values never arrived after the tuples were sent", exp_q.size());
		exp_q.delete();
	end
endtask

task automatic fill_random_tree(input int depth, input int feat_bits);
	logic [31:0] r;
	for (int i = 0; i < (1 << (depth + 1)) - 1; i++) begin
		ref_weight[i] = random_bits(32);
	end
	for (int i = 0; i < (1 << depth) - 1; i++) begin
		r = random_bits(feat_bits);
		ref_findex[i] = '0;
		ref_findex[i][dt_pkg::FEAT_W-1:0] = r[dt_pkg::FEAT_W-1:0];
		ref_findex[i][dt_pkg::FINDEX_MISSING_BIT] = next_bit();
	end
endtask

task automatic fill_random_tuple(input int n);
	for (int i = 0; i < n; i++) begin
		tuple_buf[i] = random_bits(32);
		if (random_bits(3) == 32'd0) tuple_buf[i] = ref_missing;   // Now and then absent
	end
endtask

////////////////////////////////////////
// Directed tests
////////////////////////////////////////
task automatic stump_split();
	$display("Test: depth-1 tree, below, equal and above threshold");
	ref_weight[0] = 32'd100;
	ref_weight[1] = 32'h1111_0001;                  // Left leaf
	ref_weight[2] = 32'h2222_0002;                  // Right leaf
	ref_findex[0] = 16'h0002;
	program_tree(1, 32'hdead_beef);
	for (int k = 0; k < STUMP_N; k++) begin
		fill_random_tuple(4);
		tuple_buf[2] = 32'd99 + 32'(k);             // 99, 100, 101
		send_tuple(4);
	end
	wait_drain();
endtask

task automatic random_depth3();
	$display("Test: random depth-3 tree, tuples back to back");
	fill_random_tree(3, 3);
	program_tree(3, random_bits(32));
	for (int k = 0; k < RAND_N; k++) begin
		fill_random_tuple(8);
		send_tuple(8);
	end
	wait_drain();
endtask

task automatic missing_routes();
	logic [31:0] miss;
	$display("Test: missing features with the flag clear and set");
	miss = 32'h7000_0000;                           // Compare alone would send it right at 0
	ref_weight[0] = 32'd0;
	ref_weight[1] = 32'h7fff_ffff;                  // Compare alone would send it left
	ref_weight[2] = 32'd0;
	for (int i = 3; i < 7; i++) begin
		ref_weight[i] = 32'hc0de_0000 + 32'(i);
	end
	ref_findex[0] = 16'h0000;                       // Feature 0 with missing going left
	ref_findex[1] = 16'h8001;                       // Feature 1 with missing going right
	ref_findex[2] = 16'h0001;
	program_tree(2, miss);
	for (int k = 0; k < MISS_N; k++) begin
		tuple_buf[0] = k[1] ? 32'd10 : miss;
		tuple_buf[1] = k[0] ? 32'd5 : miss;
		send_tuple(2);
	end
	wait_drain();
endtask

task automatic signed_order();
	logic [31:0] feat_a [SIGN_N];
	logic [31:0] feat_b [SIGN_N];
	$display("Test: signed thresholds and features");
	ref_weight[0] = -32'sd100;
	ref_weight[1] = -32'sd1000;
	ref_weight[2] = 32'sd50;
	for (int i = 3; i < 7; i++) begin
		ref_weight[i] = 32'h5000_0000 + 32'(i);
	end
	ref_findex[0] = 16'h0000;
	ref_findex[1] = 16'h0001;
	ref_findex[2] = 16'h0001;
	// Mixed signs, equal values and both extremes
	feat_a[0] = -32'sd50;
	feat_b[0] = -32'sd999;
	feat_a[1] = -32'sd150;
	feat_b[1] = -32'sd1000;
	feat_a[2] = -32'sd2000;
	feat_b[2] = 32'h8000_0000;
	feat_a[3] = 32'h7fff_ffff;
	feat_b[3] = 32'sd100;
	feat_a[4] = -32'sd100;
	feat_b[4] = 32'hffff_ffff;
	feat_a[5] = 32'h8000_0000;
	feat_b[5] = 32'h7fff_ffff;
	program_tree(2, 32'h5a5a_5a5a);
	for (int k = 0; k < SIGN_N; k++) begin
		tuple_buf[0] = feat_a[k];
		tuple_buf[1] = feat_b[k];
		send_tuple(2);
	end
	wait_drain();
endtask

task automatic backpressure_stream();
	$display("Test: %0d short tuples into a depth-7 tree", BP_N);
	fill_random_tree(7, 1);
	program_tree(7, random_bits(32));
	stall_seen = 1'b0;
	for (int k = 0; k < BP_N; k++) begin
		fill_random_tuple(2);
		send_tuple(2);
	end
	wait_drain();
	assert (stall_seen) else begin
		other_cnt++;
		$display("in_ready never dropped while all tuple slots should have been full");
	end
endtask

task automatic reprogram_tree();
	$display("Test: reprogram with a depth-4 tree");
	fill_random_tree(4, 3);
	program_tree(4, random_bits(32));
	for (int k = 0; k < REPROG_N; k++) begin
		fill_random_tuple(8);
		send_tuple(8);
	end
	wait_drain();
endtask

`endif

// ==== tb/tb_dt_pu.sv ====
`default_nettype none

module tb_dt_pu;

	timeunit 1ns;
	timeprecision 1ps;

	// Tuples per test, with the run limit worked out from them
	localparam int STUMP_N  = 3;
	localparam int RAND_N   = 12;
	localparam int MISS_N   = 4;
	localparam int SIGN_N   = 6;
	localparam int BP_N     = 40;
	localparam int REPROG_N = 8;
	localparam int LIMIT_CYCLES = STUMP_N * (6 * 1 + 10) + RAND_N * (6 * 3 + 10)
		+ MISS_N * (6 * 2 + 10) + SIGN_N * (6 * 2 + 10) + BP_N * (6 * 7 + 10)
		+ REPROG_N * (6 * 4 + 10) + 1500;              // Margin for programming and reset
	localparam int DRAIN_CYCLES = dt_pkg::NUM_SLOTS * (6 * 7 + 10);

	logic                        clk;
	logic                        rst_n;
	logic [dt_pkg::DATA_W-1:0]   in_data;
	logic                        in_valid;
	logic                        in_last;
	dt_pkg::word_kind_e          in_kind;
	logic                        in_ready;
	logic [dt_pkg::DATA_W-1:0]   leaf_value;
	logic                        leaf_valid;

	// Reference tree, breadth-first like the DUT memories
	logic [dt_pkg::DATA_W-1:0]   ref_weight [0:(1 << dt_pkg::NODE_W)-1];
	logic [dt_pkg::FINDEX_W-1:0] ref_findex [0:(1 << dt_pkg::NODE_W)-1];
	int                          ref_depth;
	logic [dt_pkg::DATA_W-1:0]   ref_missing;
	logic [dt_pkg::DATA_W-1:0]   tuple_buf [0:(1 << dt_pkg::FEAT_W)-1];
	logic [dt_pkg::DATA_W-1:0]   exp_q [$];         // Leaves in arrival order
	logic [dt_pkg::DATA_W-1:0]   exp_leaf;
	logic [31:0]                 lfsr_state;
	logic                        stall_seen;        // in_ready held a tuple word back
	int                          cycle_cnt = 0;
	int                          mismatch_cnt = 0;
	int                          extra_cnt = 0;
	int                          missing_cnt = 0;
	int                          other_cnt = 0;

	dt_pu u_dt_pu (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_data    (in_data),
		.in_valid   (in_valid),
		.in_last    (in_last),
		.in_kind    (in_kind),
		.in_ready   (in_ready),
		.leaf_value (leaf_value),
		.leaf_valid (leaf_valid)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;                      // 8 ns period
	end

	////////////////////////////////////////
	// Stimulus helpers and reference model
	////////////////////////////////////////
	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic next_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], next_bit()};              // One step per bit
		end
		return v;
	endfunction

	// Walk the tree from the root for the tuple in tuple_buf
	function automatic logic [dt_pkg::DATA_W-1:0] expected_leaf();
		int                        idx;
		logic                      right;
		logic [dt_pkg::DATA_W-1:0] f;
		idx = 0;
		for (int lvl = 0; lvl < ref_depth; lvl++) begin
			f = tuple_buf[ref_findex[idx][dt_pkg::FEAT_W-1:0]];
			if (f == ref_missing) right = ref_findex[idx][dt_pkg::FINDEX_MISSING_BIT];
			else right = $signed(f) >= $signed(ref_weight[idx]);
			idx = 2 * idx + 1 + int'(right);        // Left 2i+1, right 2i+2
		end
		return ref_weight[idx];
	endfunction

	task automatic print_counts();
		$display("Errors: %0d wrong values, %0d unexpected leaves, %0d missing leaves, %0d other",
			mismatch_cnt, extra_cnt, missing_cnt, other_cnt);
	endtask

	`include "dt_pu_tests.svh"

	////////////////////////////////////////
	// Result monitor and run limit
	////////////////////////////////////////
	always @(negedge clk) begin
		if (!rst_n) begin
			assert (in_ready !== 1'b1 && leaf_valid !== 1'b1) else begin
				other_cnt++;
				$display("in_ready or leaf_valid went high during reset");
			end
		end else if (leaf_valid) begin
			assert (exp_q.size() > 0) else begin
				extra_cnt++;
				$display("Leaf value %h arrived with no tuple waiting for it", leaf_value);
			end
			if (exp_q.size() > 0) begin
				exp_leaf = exp_q.pop_front();
				assert (leaf_value === exp_leaf) else begin
					mismatch_cnt++;
					$display("[FAIL] leaf_value: got %h, expected %h", leaf_value, exp_leaf);
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= LIMIT_CYCLES) begin
			$display("Run stopped after %0d cycles, tests did not finish", cycle_cnt);
			print_counts();
			$display("Verification failed");
			$finish;
		end
	end

	initial begin
		lfsr_state = 32'hfdd5_afa2;
		stall_seen = 1'b0;
		rst_n      = 1'b0;
		in_data    = '0;
		in_valid   = 1'b0;
		in_last    = 1'b0;
		in_kind    = dt_pkg::kind_tuple;
		repeat (8) @(negedge clk);                  // 8 cycles of reset
		rst_n = 1'b1;
		stump_split();
		random_depth3();
		missing_routes();
		signed_order();
		backpressure_stream();
		reprogram_tree();
		print_counts();
		if (mismatch_cnt + extra_cnt + missing_cnt + other_cnt == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/dt_pu.sv ====
`default_nettype none

module dt_pu (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire  [dt_pkg::DATA_W-1:0]  in_data,
	input  wire                        in_valid,
	input  wire                        in_last,
	input  wire  dt_pkg::word_kind_e   in_kind,
	output logic                       in_ready,
	output logic [dt_pkg::DATA_W-1:0]  leaf_value,
	output logic                       leaf_valid
);

	// Feature store to issue
	logic                                     tuple_avail;
	logic [dt_pkg::SLOT_W-1:0]                tuple_slot;
	logic                                     tuple_pop;

	// Issue to node read
	logic                                     issue_valid;
	logic [dt_pkg::SLOT_W-1:0]                issue_slot;
	logic [dt_pkg::NODE_W-1:0]                issue_index;
	logic [dt_pkg::LEVEL_W-1:0]               issue_level;

	// Node read to compare
	logic                                     node_valid;
	logic [dt_pkg::SLOT_W-1:0]                node_slot;
	logic [dt_pkg::NODE_W-1:0]                node_index;
	logic [dt_pkg::LEVEL_W-1:0]               node_level;
	logic [dt_pkg::DATA_W-1:0]                node_weight;
	logic [dt_pkg::FINDEX_W-1:0]              node_findex;

	// Compare back to the other stages
	logic                                     feat_rd_en;
	logic [dt_pkg::SLOT_W+dt_pkg::FEAT_W-1:0] feat_rd_addr;
	logic [dt_pkg::DATA_W-1:0]                feat_rd_data;
	logic                                     rec_valid;
	logic [dt_pkg::SLOT_W-1:0]                rec_slot;
	logic [dt_pkg::NODE_W-1:0]                rec_index;
	logic [dt_pkg::LEVEL_W-1:0]               rec_level;
	logic                                     leaf_req;
	logic [dt_pkg::NODE_W-1:0]                leaf_index;
	logic                                     tuple_done;

	////////////////////////////////////////
	// Traversal loop
	////////////////////////////////////////
	dt_feature_store u_feature_store (
		.clk, .rst_n,
		.in_data, .in_valid, .in_last, .in_kind, .in_ready,
		.tuple_pop, .tuple_avail, .tuple_slot,
		.feat_rd_en, .feat_rd_addr, .feat_rd_data,
		.tuple_done
	);

	dt_issue_stage u_issue_stage (
		.clk, .rst_n,
		.tuple_avail, .tuple_slot, .tuple_pop,
		.rec_valid, .rec_slot, .rec_index, .rec_level,
		.issue_valid, .issue_slot, .issue_index, .issue_level
	);

	dt_node_read_stage u_node_read_stage (
		.clk, .rst_n,
		.in_data, .in_valid, .in_kind,
		.issue_valid, .issue_slot, .issue_index, .issue_level,
		.leaf_req, .leaf_index,
		.node_valid, .node_slot, .node_index, .node_level, .node_weight, .node_findex,
		.leaf_value, .leaf_valid
	);

	dt_compare_stage u_compare_stage (
		.clk, .rst_n,
		.in_data, .in_valid, .in_kind,
		.node_valid, .node_slot, .node_index, .node_level, .node_weight, .node_findex,
		.feat_rd_data, .feat_rd_en, .feat_rd_addr,
		.rec_valid, .rec_slot, .rec_index, .rec_level,
		.leaf_req, .leaf_index, .tuple_done
	);

endmodule

`default_nettype wire

// ==== source/dt_compare_stage.sv ====
`default_nettype none

module dt_compare_stage (
	input  wire                                       clk,
	input  wire                                       rst_n,
	input  wire  [dt_pkg::DATA_W-1:0]                 in_data,
	input  wire                                       in_valid,
	input  wire  dt_pkg::word_kind_e                  in_kind,
	input  wire                                       node_valid,
	input  wire  [dt_pkg::SLOT_W-1:0]                 node_slot,
	input  wire  [dt_pkg::NODE_W-1:0]                 node_index,
	input  wire  [dt_pkg::LEVEL_W-1:0]                node_level,
	input  wire  [dt_pkg::DATA_W-1:0]                 node_weight,
	input  wire  [dt_pkg::FINDEX_W-1:0]               node_findex,
	input  wire  [dt_pkg::DATA_W-1:0]                 feat_rd_data,
	output logic                                      feat_rd_en,
	output logic [dt_pkg::SLOT_W+dt_pkg::FEAT_W-1:0]  feat_rd_addr,
	output logic                                      rec_valid,
	output logic [dt_pkg::SLOT_W-1:0]                 rec_slot,
	output logic [dt_pkg::NODE_W-1:0]                 rec_index,
	output logic [dt_pkg::LEVEL_W-1:0]                rec_level,
	output logic                                      leaf_req,
	output logic [dt_pkg::NODE_W-1:0]                 leaf_index,
	output logic                                      tuple_done
);

	// Configuration
	logic [dt_pkg::LEVEL_W-1:0] depth;
	logic [dt_pkg::DATA_W-1:0]  missing_val;      // Feature value meaning "absent"
	logic [dt_pkg::LEVEL_W-1:0] last_level;

	// Node fields held while the feature is fetched
	logic [dt_pkg::MEM_LAT-1:0] c_vld;
	logic [dt_pkg::SLOT_W-1:0]  c_slot   [dt_pkg::MEM_LAT];
	logic [dt_pkg::NODE_W-1:0]  c_index  [dt_pkg::MEM_LAT];
	logic [dt_pkg::LEVEL_W-1:0] c_level  [dt_pkg::MEM_LAT];
	logic [dt_pkg::DATA_W-1:0]  c_weight [dt_pkg::MEM_LAT];
	logic [dt_pkg::MEM_LAT-1:0] c_miss_right;

	// Decision at the end of the fetch
	logic                       cmp_valid;
	logic                       is_missing;
	logic                       go_right;
	logic                       at_last;
	logic [dt_pkg::NODE_W-1:0]  child_index;
	logic [dt_pkg::NODE_W-1:0]  next_index;       // Shared by loop and leaf read

	////////////////////////////////////////
	// Configuration registers
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			depth       <= '0;
			missing_val <= '0;
		end else if (in_valid) begin
			if (in_kind == dt_pkg::kind_depth)   depth       <= in_data[dt_pkg::LEVEL_W-1:0];
			if (in_kind == dt_pkg::kind_missing) missing_val <= in_data;
		end
	end

	assign last_level = depth - 1'b1;             // Level of the deepest internal nodes

	////////////////////////////////////////
	// Feature fetch
	////////////////////////////////////////
	assign feat_rd_en   = node_valid;
	assign feat_rd_addr = {node_slot, node_findex[dt_pkg::FEAT_W-1:0]};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			c_vld <= '0;
		end else begin
			c_vld <= {c_vld[dt_pkg::MEM_LAT-2:0], node_valid};
		end
	end

	always_ff @(posedge clk) begin
		c_slot[0]       <= node_slot;
		c_index[0]      <= node_index;
		c_level[0]      <= node_level;
		c_weight[0]     <= node_weight;
		c_miss_right[0] <= node_findex[dt_pkg::FINDEX_MISSING_BIT];
		for (int i = 1; i < dt_pkg::MEM_LAT; i++) begin
			c_slot[i]       <= c_slot[i-1];
			c_index[i]      <= c_index[i-1];
			c_level[i]      <= c_level[i-1];
			c_weight[i]     <= c_weight[i-1];
			c_miss_right[i] <= c_miss_right[i-1];
		end
	end

	////////////////////////////////////////
	// Compare and next index
	////////////////////////////////////////
	assign cmp_valid  = c_vld[dt_pkg::MEM_LAT-1];
	assign is_missing = feat_rd_data == missing_val;

	// Right when feature >= threshold, signed; missing follows the node flag
	assign go_right = is_missing ? c_miss_right[dt_pkg::MEM_LAT-1]
		: ($signed(feat_rd_data) >= $signed(c_weight[dt_pkg::MEM_LAT-1]));

	// 2i+1 left, 2i+2 right
	assign child_index = {c_index[dt_pkg::MEM_LAT-1][dt_pkg::NODE_W-2:0], 1'b1}
		+ {{(dt_pkg::NODE_W-1){1'b0}}, go_right};
	assign at_last = c_level[dt_pkg::MEM_LAT-1] == last_level;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rec_valid <= 1'b0;
			leaf_req  <= 1'b0;
		end else begin
			rec_valid <= cmp_valid & ~at_last;        // Another level to go
			leaf_req  <= cmp_valid & at_last;         // Child is a leaf
		end
	end

	always_ff @(posedge clk) begin
		rec_slot   <= c_slot[dt_pkg::MEM_LAT-1];
		next_index <= child_index;
		rec_level  <= c_level[dt_pkg::MEM_LAT-1] + 1'b1;
	end

	assign rec_index  = next_index;
	assign leaf_index = next_index;
	assign tuple_done = leaf_req;                 // Oldest slot no longer needed

endmodule

`default_nettype wire

// ==== source/dt_node_read_stage.sv ====
`default_nettype none

module dt_node_read_stage (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire  [dt_pkg::DATA_W-1:0]    in_data,
	input  wire                          in_valid,
	input  wire  dt_pkg::word_kind_e     in_kind,
	input  wire                          issue_valid,
	input  wire  [dt_pkg::SLOT_W-1:0]    issue_slot,
	input  wire  [dt_pkg::NODE_W-1:0]    issue_index,
	input  wire  [dt_pkg::LEVEL_W-1:0]   issue_level,
	input  wire                          leaf_req,
	input  wire  [dt_pkg::NODE_W-1:0]    leaf_index,
	output logic                         node_valid,
	output logic [dt_pkg::SLOT_W-1:0]    node_slot,
	output logic [dt_pkg::NODE_W-1:0]    node_index,
	output logic [dt_pkg::LEVEL_W-1:0]   node_level,
	output logic [dt_pkg::DATA_W-1:0]    node_weight,
	output logic [dt_pkg::FINDEX_W-1:0]  node_findex,
	output logic [dt_pkg::DATA_W-1:0]    leaf_value,
	output logic                         leaf_valid
);

	// Thresholds and leaves share one memory, indexed by node
	logic [dt_pkg::DATA_W-1:0]   weight_mem [0:(1 << dt_pkg::NODE_W)-1];
	logic [dt_pkg::FINDEX_W-1:0] findex_mem [0:(1 << dt_pkg::NODE_W)-1];
	logic [dt_pkg::NODE_W-1:0]   w_cnt;           // Weight program counter
	logic [dt_pkg::NODE_W-1:0]   f_cnt;           // Feature-index program counter
	logic                        w_we;
	logic                        f_we;

	// Port A pipeline, stage 0 is the raw read
	logic [dt_pkg::MEM_LAT-1:0]  a_vld;
	logic [dt_pkg::SLOT_W-1:0]   a_slot   [dt_pkg::MEM_LAT];
	logic [dt_pkg::NODE_W-1:0]   a_index  [dt_pkg::MEM_LAT];
	logic [dt_pkg::LEVEL_W-1:0]  a_level  [dt_pkg::MEM_LAT];
	logic [dt_pkg::DATA_W-1:0]   a_weight [dt_pkg::MEM_LAT];
	logic [dt_pkg::FINDEX_W-1:0] a_findex [dt_pkg::MEM_LAT];

	// Port B pipeline
	logic [dt_pkg::MEM_LAT-1:0]  b_vld;
	logic [dt_pkg::DATA_W-1:0]   b_data   [dt_pkg::MEM_LAT];

	////////////////////////////////////////
	// Programming
	////////////////////////////////////////
	assign w_we = in_valid & (in_kind == dt_pkg::kind_weight);
	assign f_we = in_valid & (in_kind == dt_pkg::kind_findex);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			w_cnt <= '0;
			f_cnt <= '0;
		end else if (in_valid && in_kind == dt_pkg::kind_depth) begin
			w_cnt <= '0;                              // New tree loads from address 0
			f_cnt <= '0;
		end else begin
			if (w_we) w_cnt <= w_cnt + 1'b1;
			if (f_we) f_cnt <= f_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (w_we) weight_mem[w_cnt] <= in_data;
		if (f_we) findex_mem[f_cnt] <= in_data[dt_pkg::FINDEX_W-1:0];
	end

	////////////////////////////////////////
	// Port A, node read
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			a_vld <= '0;
			b_vld <= '0;
		end else begin
			a_vld <= {a_vld[dt_pkg::MEM_LAT-2:0], issue_valid};
			b_vld <= {b_vld[dt_pkg::MEM_LAT-2:0], leaf_req};
		end
	end

	always_ff @(posedge clk) begin
		if (issue_valid) begin
			a_weight[0] <= weight_mem[issue_index];
			a_findex[0] <= findex_mem[issue_index];
		end
		a_slot[0]  <= issue_slot;                   // Sideband follows the read
		a_index[0] <= issue_index;
		a_level[0] <= issue_level;
		for (int i = 1; i < dt_pkg::MEM_LAT; i++) begin
			a_weight[i] <= a_weight[i-1];
			a_findex[i] <= a_findex[i-1];
			a_slot[i]   <= a_slot[i-1];
			a_index[i]  <= a_index[i-1];
			a_level[i]  <= a_level[i-1];
		end
	end

	assign node_valid  = a_vld[dt_pkg::MEM_LAT-1];
	assign node_slot   = a_slot[dt_pkg::MEM_LAT-1];
	assign node_index  = a_index[dt_pkg::MEM_LAT-1];
	assign node_level  = a_level[dt_pkg::MEM_LAT-1];
	assign node_weight = a_weight[dt_pkg::MEM_LAT-1];
	assign node_findex = a_findex[dt_pkg::MEM_LAT-1];

	////////////////////////////////////////
	// Port B, leaf read
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (leaf_req) begin
			b_data[0] <= weight_mem[leaf_index];
		end
		for (int i = 1; i < dt_pkg::MEM_LAT; i++) begin
			b_data[i] <= b_data[i-1];
		end
	end

	assign leaf_valid = b_vld[dt_pkg::MEM_LAT-1];  // Single pulse per tuple
	assign leaf_value = b_data[dt_pkg::MEM_LAT-1];

endmodule

`default_nettype wire

// ==== source/dt_issue_stage.sv ====
`default_nettype none

module dt_issue_stage (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire                         tuple_avail,
	input  wire  [dt_pkg::SLOT_W-1:0]   tuple_slot,
	input  wire                         rec_valid,
	input  wire  [dt_pkg::SLOT_W-1:0]   rec_slot,
	input  wire  [dt_pkg::NODE_W-1:0]   rec_index,
	input  wire  [dt_pkg::LEVEL_W-1:0]  rec_level,
	output logic                        tuple_pop,
	output logic                        issue_valid,
	output logic [dt_pkg::SLOT_W-1:0]   issue_slot,
	output logic [dt_pkg::NODE_W-1:0]   issue_index,
	output logic [dt_pkg::LEVEL_W-1:0]  issue_level
);

	// New tuple only takes an empty loop slot
	assign tuple_pop = tuple_avail & ~rec_valid;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			issue_valid <= 1'b0;
		end else begin
			issue_valid <= rec_valid | tuple_avail;
		end
	end

	////////////////////////////////////////
	// Issued traversal step
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rec_valid) begin
			issue_slot  <= rec_slot;                  // Node coming back round the loop
			issue_index <= rec_index;
			issue_level <= rec_level;
		end else begin
			issue_slot  <= tuple_slot;                // Fresh tuple enters at the root
			issue_index <= '0;
			issue_level <= '0;
		end
	end

endmodule

`default_nettype wire

// ==== source/dt_feature_store.sv ====
`default_nettype none

module dt_feature_store (
	input  wire                                        clk,
	input  wire                                        rst_n,
	input  wire  [dt_pkg::DATA_W-1:0]                  in_data,
	input  wire                                        in_valid,
	input  wire                                        in_last,
	input  wire  dt_pkg::word_kind_e                   in_kind,
	input  wire                                        tuple_pop,
	input  wire                                        feat_rd_en,
	input  wire  [dt_pkg::SLOT_W+dt_pkg::FEAT_W-1:0]   feat_rd_addr,
	input  wire                                        tuple_done,
	output logic                                       in_ready,
	output logic                                       tuple_avail,
	output logic [dt_pkg::SLOT_W-1:0]                  tuple_slot,
	output logic [dt_pkg::DATA_W-1:0]                  feat_rd_data
);

	// One row of 2^FEAT_W features per slot
	logic [dt_pkg::DATA_W-1:0] feat_mem [0:(1 << (dt_pkg::SLOT_W + dt_pkg::FEAT_W))-1];
	logic [dt_pkg::DATA_W-1:0] rd_q;              // Raw read, before output register

	// Pointers carry a wrap bit so full and empty differ
	logic [dt_pkg::SLOT_W:0]   wr_ptr;            // Slot being filled
	logic [dt_pkg::SLOT_W:0]   iss_ptr;           // Next complete slot to issue
	logic [dt_pkg::SLOT_W:0]   free_ptr;          // Oldest slot still in use
	logic [dt_pkg::SLOT_W:0]   wr_ptr_nxt;
	logic [dt_pkg::SLOT_W:0]   free_ptr_nxt;
	logic [dt_pkg::SLOT_W:0]   used_nxt;
	logic [dt_pkg::FEAT_W-1:0] feat_cnt;          // Feature index within current slot
	logic                      feat_we;
	logic                      tuple_end;

	////////////////////////////////////////
	// Tuple write side
	////////////////////////////////////////
	assign feat_we   = in_valid & in_ready & (in_kind == dt_pkg::kind_tuple);
	assign tuple_end = feat_we & in_last;         // Slot complete

	always_ff @(posedge clk) begin
		if (feat_we) begin
			feat_mem[{wr_ptr[dt_pkg::SLOT_W-1:0], feat_cnt}] <= in_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			feat_cnt <= '0;
		end else if (tuple_end) begin
			feat_cnt <= '0;                           // Next tuple starts at feature 0
		end else if (feat_we) begin
			feat_cnt <= feat_cnt + 1'b1;
		end
	end

	////////////////////////////////////////
	// Slot bookkeeping
	////////////////////////////////////////
	assign wr_ptr_nxt   = wr_ptr + {{dt_pkg::SLOT_W{1'b0}}, tuple_end};
	assign free_ptr_nxt = free_ptr + {{dt_pkg::SLOT_W{1'b0}}, tuple_done};
	assign used_nxt     = wr_ptr_nxt - free_ptr_nxt;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr   <= '0;
			iss_ptr  <= '0;
			free_ptr <= '0;
			in_ready <= 1'b0;
		end else begin
			wr_ptr   <= wr_ptr_nxt;
			free_ptr <= free_ptr_nxt;
			if (tuple_pop) begin
				iss_ptr <= iss_ptr + 1'b1;
			end
			in_ready <= used_nxt < dt_pkg::NUM_SLOTS; // Room left for another tuple
		end
	end

	// Complete tuples waiting between write and issue pointers
	assign tuple_avail = wr_ptr != iss_ptr;
	assign tuple_slot  = iss_ptr[dt_pkg::SLOT_W-1:0];

	////////////////////////////////////////
	// Feature read port
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (feat_rd_en) begin
			rd_q <= feat_mem[feat_rd_addr];
		end
		feat_rd_data <= rd_q;                       // Output register
	end

endmodule

`default_nettype wire

// ==== source/dt_pkg.sv ====
`default_nettype none

package dt_pkg;

	////////////////////////////////////////
	// Datapath widths
	////////////////////////////////////////
	localparam int DATA_W    = 32;                  // Feature, threshold and leaf value
	localparam int NODE_W    = 8;                   // Node index, 256 tree memory entries
	localparam int LEVEL_W   = 4;                   // Tree level, depth 7 at most

	// Tuple storage
	localparam int NUM_SLOTS = 16;                  // Tuples held at once
	localparam int SLOT_W    = 4;
	localparam int FEAT_W    = 4;                   // Up to 16 features per tuple

	////////////////////////////////////////
	// Feature-index word layout
	////////////////////////////////////////
	localparam int FINDEX_W           = 16;
	localparam int FINDEX_MISSING_BIT = 15;         // Missing goes right
	// Feature index lives in [FEAT_W-1:0]

	// Read then output register
	localparam int MEM_LAT   = 2;

	// Kind of an input word
	typedef enum logic [2:0] {
		kind_tuple   = 3'd0,                    // Feature of a tuple
		kind_weight  = 3'd1,                    // Next threshold or leaf value
		kind_findex  = 3'd2,                    // Next feature-index word
		kind_depth   = 3'd3,                    // Depth in [3:0], restarts program counters
		kind_missing = 3'd4                     // Missing-value marker
	} word_kind_e;

endpackage

`default_nettype wire
